// File: src/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// ====================
// Geometry
// ====================

// Byte address width
`define DC_ABW      16
// Direct-mapped line counts
`define DC_L1_LINES 16
`define DC_L2_LINES 64
// 32-bit bus words per 16-byte line
`define DC_BEATS    4

// ====================
// Latencies
// ====================

// Cycles from L2 address to L2 read data
`define DC_L2_LAT   2
// L1 write settling before the fill is reported done
`define DC_L1_WLAT  1

`endif

// File: src/dcache_pkg.sv
`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

	// Widths that carry a meaning
	typedef logic [`DC_ABW-1:0] addr_t;
	typedef logic [15:0]        hword_t;
	typedef logic [31:0]        bword_t;
	typedef logic [127:0]       line_t;
	typedef logic [15:0]        lmask_t;
	typedef logic [1:0]         hsel_t;
	typedef logic [1:0]         lstat_t;

	// Line status codes, same encoding as the bus fault lines
	localparam lstat_t LS_OK  = 2'd0;
	localparam lstat_t LS_WRV = 2'd1;
	localparam lstat_t LS_RDV = 2'd2;
	localparam lstat_t LS_ERR = 2'd3;

	// Controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_L2_WAIT,
		ST_L2_CHECK,
		ST_BUS_ACK,
		ST_BUS_NACK,
		ST_FILL_DONE,
		ST_SETTLE
	} dc_state_e;

endpackage

`default_nettype wire

// File: src/dc_controller.sv
`default_nettype none

`include "dcache_defs.svh"

module dc_controller (
	input  wire                     clk,
	input  wire                     rst_i,
	// Processor side
	input  wire                     rd_i,
	input  wire                     wr_i,
	input  wire dcache_pkg::addr_t  adr_i,
	input  wire dcache_pkg::hsel_t  wsel_i,
	input  wire dcache_pkg::hword_t wdat_i,
	input  wire                     inv_i,
	input  wire dcache_pkg::addr_t  inv_adr_i,
	// Cache lookups
	input  wire                     l1_hit_i,
	input  wire                     l2_rhit_i,
	input  wire                     l2_whit_i,
	input  wire dcache_pkg::line_t  l2_rdat_i,
	input  wire dcache_pkg::lstat_t l2_rstat_i,
	// L1 control
	output dcache_pkg::addr_t       l1_adr_o,
	output logic                    l1_wr_o,
	output logic                    l1_inv_o,
	output dcache_pkg::lmask_t      l1_mask_o,
	output dcache_pkg::line_t       l1_dat_o,
	output dcache_pkg::lstat_t      l1_stat_o,
	// L2 control
	output dcache_pkg::addr_t       l2_adr_o,
	output logic                    l2_ld_o,
	output dcache_pkg::lmask_t      l2_mask_o,
	output dcache_pkg::line_t       l2_dat_o,
	output dcache_pkg::lstat_t      l2_stat_o,
	// Status
	output logic                    idle_o,
	output logic                    done_o,
	output logic [31:0]             fill_cnt_o,
	// Bus master
	output logic                    cyc_o,
	output logic                    stb_o,
	output logic [2:0]              cti_o,
	output dcache_pkg::addr_t       adr_o,
	output logic [3:0]              sel_o,
	input  wire dcache_pkg::bword_t dat_i,
	input  wire                     ack_i,
	input  wire                     err_i,
	input  wire                     wrv_i,
	input  wire                     rdv_i,
	input  wire                     bok_i
);
	import dcache_pkg::*;

	// Byte offset bits within a line, beat index bits
	localparam int OFF_W  = $clog2(`DC_BEATS * 4);
	localparam int BEAT_W = $clog2(`DC_BEATS);

	dc_state_e  state;
	logic [2:0] cnt;
	logic       bus_fill;
	logic       inv_pend;
	addr_t      inv_adr_r;
	addr_t      fill_adr;
	line_t      line_r;
	lstat_t     stat_r;
	logic       beat;
	logic       fault;
	lmask_t     wr_mask;
	line_t      wr_line;

	// Any response ends the current beat
	assign beat  = ack_i | err_i | wrv_i | rdv_i;
	assign fault = err_i | wrv_i | rdv_i;

	// Halfword store placed into its byte lanes
	assign wr_mask = lmask_t'(wsel_i) << adr_i[OFF_W-1:0];
	assign wr_line = line_t'(wdat_i) << {adr_i[OFF_W-1:0], 3'b000};

	// Processor lookups only valid with no invalidate waiting
	assign idle_o = (state == ST_IDLE) && !inv_pend;
	// Full word reads only
	assign sel_o  = cyc_o ? 4'hf : 4'h0;

	// ====================
	// Cache port steering
	// ====================

	always_comb begin
		// Refill defaults, whole line from the buffer
		l1_adr_o  = fill_adr;
		l2_adr_o  = fill_adr;
		l1_wr_o   = 1'b0;
		l1_inv_o  = 1'b0;
		l2_ld_o   = 1'b0;
		l1_mask_o = '1;
		l2_mask_o = '1;
		l1_dat_o  = line_r;
		l2_dat_o  = line_r;
		l1_stat_o = stat_r;
		l2_stat_o = stat_r;
		if (state == ST_IDLE) begin
			// L2 read starts here so a miss finds it in flight
			l2_adr_o = adr_i;
			if (inv_pend) begin
				l1_adr_o = inv_adr_r;
				l1_inv_o = 1'b1;
			end else begin
				l1_adr_o = adr_i;
				if (wr_i) begin
					// Write-through only to levels that hold the line
					l1_wr_o   = l1_hit_i;
					l2_ld_o   = l2_whit_i;
					l1_mask_o = wr_mask;
					l2_mask_o = wr_mask;
					l1_dat_o  = wr_line;
					l2_dat_o  = wr_line;
				end
			end
		end else if (state == ST_FILL_DONE) begin
			l1_wr_o = 1'b1;
			// L2 already has the line after an L2 hit
			l2_ld_o = bus_fill;
		end
	end

	// ====================
	// State machine
	// ====================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state      <= ST_IDLE;
			cnt        <= '0;
			bus_fill   <= 1'b0;
			inv_pend   <= 1'b0;
			done_o     <= 1'b0;
			fill_cnt_o <= '0;
			cyc_o      <= 1'b0;
			stb_o      <= 1'b0;
			cti_o      <= 3'b000;
		end else begin
			done_o <= 1'b0;
			case (state)
			ST_IDLE: begin
				cnt <= '0;
				// Invalidate goes ahead of everything else
				if (inv_pend)
					inv_pend <= 1'b0;
				else if (!wr_i && rd_i && !l1_hit_i)
					state <= ST_L2_WAIT;
			end
			// Let the L2 read pipeline drain
			ST_L2_WAIT: begin
				cnt <= cnt + 3'd1;
				if (cnt == 3'(`DC_L2_LAT - 2))
					state <= ST_L2_CHECK;
			end
			ST_L2_CHECK: begin
				cnt <= '0;
				if (l2_rhit_i) begin
					bus_fill <= 1'b0;
					state    <= ST_FILL_DONE;
				end else begin
					// Start the burst
					bus_fill <= 1'b1;
					cyc_o    <= 1'b1;
					stb_o    <= 1'b1;
					cti_o    <= 3'b001;
					state    <= ST_BUS_ACK;
				end
			end
			ST_BUS_ACK: begin
				if (beat) begin
					cnt <= cnt + 3'd1;
					if (fault || cnt == 3'(`DC_BEATS - 1)) begin
						cyc_o <= 1'b0;
						stb_o <= 1'b0;
						cti_o <= 3'b000;
						state <= ST_FILL_DONE;
					end else begin
						// Flag the last beat of the burst
						if (cnt == 3'(`DC_BEATS - 2))
							cti_o <= 3'b111;
						// Slave refuses bursts, one beat at a time
						if (!bok_i) begin
							stb_o <= 1'b0;
							state <= ST_BUS_NACK;
						end
					end
				end
			end
			// Wait for the ack to clear before the next single beat
			ST_BUS_NACK: begin
				if (!ack_i) begin
					stb_o <= 1'b1;
					state <= ST_BUS_ACK;
				end
			end
			ST_FILL_DONE: begin
				cnt <= '0;
				if (bus_fill)
					fill_cnt_o <= fill_cnt_o + 32'd1;
				state <= ST_SETTLE;
			end
			ST_SETTLE: begin
				cnt <= cnt + 3'd1;
				if (cnt == 3'(`DC_L1_WLAT - 1)) begin
					done_o <= 1'b1;
					state  <= ST_IDLE;
				end
			end
			default: state <= ST_IDLE;
			endcase
			// A new request overrides the one just served
			if (inv_i)
				inv_pend <= 1'b1;
		end
	end

	// ====================
	// Line assembly
	// ====================

	always_ff @(posedge clk) begin
		if (inv_i)
			inv_adr_r <= inv_adr_i;
		case (state)
		ST_IDLE: fill_adr <= {adr_i[`DC_ABW-1:OFF_W], {OFF_W{1'b0}}};
		ST_L2_CHECK: begin
			if (l2_rhit_i) begin
				line_r <= l2_rdat_i;
				stat_r <= l2_rstat_i;
			end else begin
				stat_r <= LS_OK;
				adr_o  <= fill_adr;
			end
		end
		ST_BUS_ACK: begin
			if (beat) begin
				adr_o <= adr_o + addr_t'(4);
				// Faulted line is zero filled with the fault status
				if (wrv_i) begin
					line_r <= '0;
					stat_r <= LS_WRV;
				end else if (rdv_i) begin
					line_r <= '0;
					stat_r <= LS_RDV;
				end else if (err_i) begin
					line_r <= '0;
					stat_r <= LS_ERR;
				end else begin
					line_r[{cnt[BEAT_W-1:0], 5'b00000} +: 32] <= dat_i;
				end
			end
		end
		default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: src/dc_l1_cache.sv
`default_nettype none

`include "dcache_defs.svh"

module dc_l1_cache (
	input  wire                     clk,
	input  wire                     rst_i,
	input  wire dcache_pkg::addr_t  adr_i,
	input  wire                     wr_i,
	input  wire                     inv_i,
	input  wire dcache_pkg::lmask_t mask_i,
	input  wire dcache_pkg::line_t  dat_i,
	input  wire dcache_pkg::lstat_t stat_i,
	output logic                    hit_o,
	output dcache_pkg::hword_t      rdat_o,
	output dcache_pkg::lstat_t      rstat_o
);
	import dcache_pkg::*;

	localparam int OFF_W = $clog2(`DC_BEATS * 4);
	localparam int IDX_W = $clog2(`DC_L1_LINES);
	localparam int TAG_W = `DC_ABW - IDX_W - OFF_W;

	// Line arrays
	logic [TAG_W-1:0]        tag_mem  [`DC_L1_LINES];
	lstat_t                  stat_mem [`DC_L1_LINES];
	line_t                   data_mem [`DC_L1_LINES];
	logic [`DC_L1_LINES-1:0] valid;

	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic             full;

	assign idx  = adr_i[OFF_W +: IDX_W];
	assign tag  = adr_i[`DC_ABW-1 -: TAG_W];
	// Only a whole-line write allocates
	assign full = &mask_i;

	always_ff @(posedge clk) begin
		if (rst_i)
			valid <= '0;
		else if (inv_i)
			valid[idx] <= 1'b0;
		else if (wr_i && full)
			valid[idx] <= 1'b1;
	end

	// Byte-masked line write
	always_ff @(posedge clk) begin
		if (wr_i) begin
			for (int b = 0; b < $bits(lmask_t); b++) begin
				if (mask_i[b])
					data_mem[idx][b*8 +: 8] <= dat_i[b*8 +: 8];
			end
			if (full) begin
				tag_mem[idx]  <= tag;
				stat_mem[idx] <= stat_i;
			end
		end
	end

	// Combinational lookup, halfword picked by address
	assign hit_o   = valid[idx] && (tag_mem[idx] == tag);
	assign rdat_o  = data_mem[idx][{adr_i[OFF_W-1:1], 4'h0} +: 16];
	assign rstat_o = stat_mem[idx];

endmodule

`default_nettype wire

// File: src/dc_l2_cache.sv
`default_nettype none

`include "dcache_defs.svh"

module dc_l2_cache (
	input  wire                     clk,
	input  wire                     rst_i,
	input  wire dcache_pkg::addr_t  radr_i,
	input  wire dcache_pkg::addr_t  wadr_i,
	input  wire                     ld_i,
	input  wire dcache_pkg::lmask_t mask_i,
	input  wire dcache_pkg::line_t  dat_i,
	input  wire dcache_pkg::lstat_t stat_i,
	output logic                    rhit_o,
	output dcache_pkg::line_t       rdat_o,
	output dcache_pkg::lstat_t      rstat_o,
	output logic                    whit_o
);
	import dcache_pkg::*;

	localparam int OFF_W = $clog2(`DC_BEATS * 4);
	localparam int IDX_W = $clog2(`DC_L2_LINES);
	localparam int TAG_W = `DC_ABW - IDX_W - OFF_W;

	// Line arrays
	logic [TAG_W-1:0]        tag_mem  [`DC_L2_LINES];
	lstat_t                  stat_mem [`DC_L2_LINES];
	line_t                   data_mem [`DC_L2_LINES];
	logic [`DC_L2_LINES-1:0] valid;

	logic [IDX_W-1:0] ridx;
	logic [IDX_W-1:0] widx;
	logic [TAG_W-1:0] rtag;
	logic [TAG_W-1:0] wtag;
	logic             full;
	logic             rd_hit;

	// Read pipeline stages
	logic [`DC_L2_LAT-1:0] hit_pipe;
	line_t                 dat_pipe  [`DC_L2_LAT];
	lstat_t                stat_pipe [`DC_L2_LAT];

	assign ridx = radr_i[OFF_W +: IDX_W];
	assign rtag = radr_i[`DC_ABW-1 -: TAG_W];
	assign widx = wadr_i[OFF_W +: IDX_W];
	assign wtag = wadr_i[`DC_ABW-1 -: TAG_W];
	assign full = &mask_i;

	// Write side tag match gates the write-through
	assign whit_o = valid[widx] && (tag_mem[widx] == wtag);
	assign rd_hit = valid[ridx] && (tag_mem[ridx] == rtag);

	always_ff @(posedge clk) begin
		if (rst_i)
			valid <= '0;
		else if (ld_i && full)
			valid[widx] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (ld_i) begin
			for (int b = 0; b < $bits(lmask_t); b++) begin
				if (mask_i[b])
					data_mem[widx][b*8 +: 8] <= dat_i[b*8 +: 8];
			end
			if (full) begin
				tag_mem[widx]  <= wtag;
				stat_mem[widx] <= stat_i;
			end
		end
	end

	// Hit flag stages
	always_ff @(posedge clk) begin
		if (rst_i) begin
			hit_pipe <= '0;
		end else begin
			hit_pipe[0] <= rd_hit;
			for (int i = 1; i < `DC_L2_LAT; i++)
				hit_pipe[i] <= hit_pipe[i-1];
		end
	end

	// Line data and status stages
	always_ff @(posedge clk) begin
		dat_pipe[0]  <= data_mem[ridx];
		stat_pipe[0] <= stat_mem[ridx];
		for (int i = 1; i < `DC_L2_LAT; i++) begin
			dat_pipe[i]  <= dat_pipe[i-1];
			stat_pipe[i] <= stat_pipe[i-1];
		end
	end

	assign rhit_o  = hit_pipe[`DC_L2_LAT-1];
	assign rdat_o  = dat_pipe[`DC_L2_LAT-1];
	assign rstat_o = stat_pipe[`DC_L2_LAT-1];

endmodule

`default_nettype wire

// File: src/dcache_top.sv
`default_nettype none

module dcache_top (
	input  wire                     clk,
	input  wire                     rst_i,
	// Processor side
	input  wire                     rd_i,
	input  wire                     wr_i,
	input  wire dcache_pkg::addr_t  adr_i,
	input  wire dcache_pkg::hsel_t  wsel_i,
	input  wire dcache_pkg::hword_t wdat_i,
	input  wire                     inv_i,
	input  wire dcache_pkg::addr_t  inv_adr_i,
	output dcache_pkg::hword_t      rdat_o,
	output dcache_pkg::lstat_t      rstat_o,
	output logic                    rhit_o,
	output logic                    done_o,
	output logic [31:0]             fill_cnt_o,
	// Bus side
	output logic                    cyc_o,
	output logic                    stb_o,
	output logic [2:0]              cti_o,
	output dcache_pkg::addr_t       adr_o,
	output logic [3:0]              sel_o,
	input  wire dcache_pkg::bword_t dat_i,
	input  wire                     ack_i,
	input  wire                     err_i,
	input  wire                     wrv_i,
	input  wire                     rdv_i,
	input  wire                     bok_i
);
	import dcache_pkg::*;

	// L1 port
	addr_t  l1_adr;
	logic   l1_hit;
	logic   l1_wr;
	logic   l1_inv;
	lmask_t l1_mask;
	line_t  l1_dat;
	lstat_t l1_stat;

	// L2 port
	addr_t  l2_adr;
	logic   l2_ld;
	logic   l2_rhit;
	logic   l2_whit;
	lmask_t l2_mask;
	line_t  l2_dat;
	line_t  l2_rdat;
	lstat_t l2_stat;
	lstat_t l2_rstat;

	logic   idle;

	// L1 lookup is at adr_i whenever the controller is idle
	assign rhit_o = idle & l1_hit;

	dc_controller u_ctrl (
		.clk        (clk),
		.rst_i      (rst_i),
		.rd_i       (rd_i),
		.wr_i       (wr_i),
		.adr_i      (adr_i),
		.wsel_i     (wsel_i),
		.wdat_i     (wdat_i),
		.inv_i      (inv_i),
		.inv_adr_i  (inv_adr_i),
		.l1_hit_i   (l1_hit),
		.l2_rhit_i  (l2_rhit),
		.l2_whit_i  (l2_whit),
		.l2_rdat_i  (l2_rdat),
		.l2_rstat_i (l2_rstat),
		.l1_adr_o   (l1_adr),
		.l1_wr_o    (l1_wr),
		.l1_inv_o   (l1_inv),
		.l1_mask_o  (l1_mask),
		.l1_dat_o   (l1_dat),
		.l1_stat_o  (l1_stat),
		.l2_adr_o   (l2_adr),
		.l2_ld_o    (l2_ld),
		.l2_mask_o  (l2_mask),
		.l2_dat_o   (l2_dat),
		.l2_stat_o  (l2_stat),
		.idle_o     (idle),
		.done_o     (done_o),
		.fill_cnt_o (fill_cnt_o),
		.cyc_o      (cyc_o),
		.stb_o      (stb_o),
		.cti_o      (cti_o),
		.adr_o      (adr_o),
		.sel_o      (sel_o),
		.dat_i      (dat_i),
		.ack_i      (ack_i),
		.err_i      (err_i),
		.wrv_i      (wrv_i),
		.rdv_i      (rdv_i),
		.bok_i      (bok_i)
	);

	dc_l1_cache u_l1 (
		.clk     (clk),
		.rst_i   (rst_i),
		.adr_i   (l1_adr),
		.wr_i    (l1_wr),
		.inv_i   (l1_inv),
		.mask_i  (l1_mask),
		.dat_i   (l1_dat),
		.stat_i  (l1_stat),
		.hit_o   (l1_hit),
		.rdat_o  (rdat_o),
		.rstat_o (rstat_o)
	);

	// Same address on both L2 ports
	dc_l2_cache u_l2 (
		.clk     (clk),
		.rst_i   (rst_i),
		.radr_i  (l2_adr),
		.wadr_i  (l2_adr),
		.ld_i    (l2_ld),
		.mask_i  (l2_mask),
		.dat_i   (l2_dat),
		.stat_i  (l2_stat),
		.rhit_o  (l2_rhit),
		.rdat_o  (l2_rdat),
		.rstat_o (l2_rstat),
		.whit_o  (l2_whit)
	);

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// 4 ns period
	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Reset held for the first 10 rising edges
	initial begin
		rst_o = 1'b1;
		repeat (10) @(posedge clk);
		rst_o <= 1'b0;
	end

endmodule

`default_nettype wire

// File: verif/tb_dcache.sv
`default_nettype none

`include "dcache_defs.svh"

module tb_dcache;
	timeunit 1ns;
	timeprecision 100ps;

	import dcache_pkg::*;

	// Per-fill limit on the wait for done_o
	localparam int FILL_LIMIT = 100;
	// Cycle budget of each test
	localparam int T_MISS  = 300;
	localparam int T_NBURST = 400;
	localparam int T_WRITE = 100;
	localparam int T_L2    = 300;
	localparam int T_FAULT = 900;
	localparam int RUN_CYC = 10 + T_MISS + T_NBURST + T_WRITE + T_L2 + T_FAULT;

	logic        clk;
	logic        rst_i;
	logic        rd_i;
	logic        wr_i;
	addr_t       adr_i;
	hsel_t       wsel_i;
	hword_t      wdat_i;
	logic        inv_i;
	addr_t       inv_adr_i;
	hword_t      rdat_o;
	lstat_t      rstat_o;
	logic        rhit_o;
	logic        done_o;
	logic [31:0] fill_cnt_o;
	logic        cyc_o;
	logic        stb_o;
	logic [2:0]  cti_o;
	addr_t       adr_o;
	logic [3:0]  sel_o;
	bword_t      dat_i;
	logic        ack_i;
	logic        err_i;
	logic        wrv_i;
	logic        rdv_i;
	logic        bok_i;

	// Bus model controls
	logic        fault_on;
	addr_t       fault_adr;
	lstat_t      fault_kind;
	// Requests served in the current bus cycle
	int          beat_no;

	int          mismatches;
	int          other_errs;
	int          checks;
	logic [31:0] exp_fills;
	addr_t       base;
	// Halfword left by the write test for the read after the invalidate
	addr_t       wt_adr;
	hword_t      wt_val;

	tb_clock u_clock (
		.clk   (clk),
		.rst_o (rst_i)
	);

	dcache_top dut (
		.clk        (clk),
		.rst_i      (rst_i),
		.rd_i       (rd_i),
		.wr_i       (wr_i),
		.adr_i      (adr_i),
		.wsel_i     (wsel_i),
		.wdat_i     (wdat_i),
		.inv_i      (inv_i),
		.inv_adr_i  (inv_adr_i),
		.rdat_o     (rdat_o),
		.rstat_o    (rstat_o),
		.rhit_o     (rhit_o),
		.done_o     (done_o),
		.fill_cnt_o (fill_cnt_o),
		.cyc_o      (cyc_o),
		.stb_o      (stb_o),
		.cti_o      (cti_o),
		.adr_o      (adr_o),
		.sel_o      (sel_o),
		.dat_i      (dat_i),
		.ack_i      (ack_i),
		.err_i      (err_i),
		.wrv_i      (wrv_i),
		.rdv_i      (rdv_i),
		.bok_i      (bok_i)
	);

	// ====================
	// Memory model
	// ====================

	// Word contents follow from the full address
	function automatic bword_t model_word(input addr_t a);
		return {a ^ 16'h5a3c, ~a + 16'h1d2b};
	endfunction

	// Little-endian halfword inside its bus word
	function automatic hword_t model_hword(input addr_t a);
		bword_t w;
		w = model_word({a[`DC_ABW-1:2], 2'b00});
		return a[1] ? w[31:16] : w[15:0];
	endfunction

	// One response per request so the master sees each beat once
	always @(posedge clk) begin
		ack_i <= 1'b0;
		err_i <= 1'b0;
		wrv_i <= 1'b0;
		rdv_i <= 1'b0;
		if (!cyc_o)
			beat_no <= 0;
		if (cyc_o && stb_o && !(ack_i || err_i || wrv_i || rdv_i)) begin
			// Only the last beat of the line ends the burst
			ctl_field_check("cti_o", {1'b0, cti_o},
				(beat_no == `DC_BEATS - 1) ? 4'b0111 : 4'b0001);
			ctl_field_check("sel_o", sel_o, 4'hf);
			beat_no <= beat_no + 1;
			if (fault_on && adr_o == fault_adr) begin
				case (fault_kind)
				LS_WRV: wrv_i <= 1'b1;
				LS_RDV: rdv_i <= 1'b1;
				default: err_i <= 1'b1;
				endcase
			end else begin
				ack_i <= 1'b1;
				dat_i <= model_word(adr_o);
			end
		end
	end

	// ====================
	// Compare tasks
	// ====================

	task automatic check_hword(input string name, input hword_t got, input hword_t exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_status(input string name, input lstat_t got, input lstat_t exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic verify_count(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// Bus control fields up to 4 bits wide
	task automatic ctl_field_check(input string name, input logic [3:0] got,
			input logic [3:0] exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// ====================
	// Helpers
	// ====================

	// Counts cycles until done_o on falling edges
	task automatic wait_done(output int n);
		n = 0;
		@(negedge clk);
		while (!done_o && n < FILL_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!done_o) begin
			other_errs++;
			$display("error: done_o did not rise within %0d cycles", FILL_LIMIT);
		end
	endtask

	// Read miss then a lookup check one cycle after done_o
	task automatic fill_and_check(input addr_t a, input hword_t exp_d, input lstat_t exp_s,
			input logic from_bus, output int n);
		@(posedge clk);
		rd_i  <= 1'b1;
		wr_i  <= 1'b0;
		adr_i <= a;
		wait_done(n);
		if (from_bus)
			exp_fills++;
		@(negedge clk);
		// Single-cycle done pulse
		expect_bit("done_o", done_o, 1'b0);
		expect_bit("rhit_o", rhit_o, 1'b1);
		check_hword("rdat_o", rdat_o, exp_d);
		compare_status("rstat_o", rstat_o, exp_s);
		verify_count("fill_cnt_o", fill_cnt_o, exp_fills);
		@(posedge clk);
		rd_i <= 1'b0;
	endtask

	task automatic invalidate_line(input addr_t a);
		@(posedge clk);
		rd_i      <= 1'b0;
		adr_i     <= a;
		inv_i     <= 1'b1;
		inv_adr_i <= a;
		@(posedge clk);
		inv_i <= 1'b0;
		// Pending invalidate is served in this cycle
		@(posedge clk);
		@(negedge clk);
		expect_bit("rhit_o", rhit_o, 1'b0);
	endtask

	// ====================
	// Directed tests
	// ====================

	task automatic read_miss_fill(input addr_t a);
		int n;
		fill_and_check(a, model_hword(a), LS_OK, 1'b1, n);
	endtask

	task automatic nonburst_fill(input addr_t a);
		int n;
		@(posedge clk);
		bok_i <= 1'b0;
		fill_and_check(a, model_hword(a), LS_OK, 1'b1, n);
		bok_i <= 1'b1;
	endtask

	task automatic write_through(input addr_t a, input addr_t cold);
		hsel_t  sel;
		hword_t d;
		hword_t old;
		hword_t merged;
		sel = hsel_t'(1 + $urandom % 3);
		d   = hword_t'($urandom);
		old = model_hword(a);
		// Selected bytes replace the old ones
		merged[7:0]  = sel[0] ? d[7:0] : old[7:0];
		merged[15:8] = sel[1] ? d[15:8] : old[15:8];
		@(posedge clk);
		rd_i   <= 1'b0;
		wr_i   <= 1'b1;
		adr_i  <= a;
		wsel_i <= sel;
		wdat_i <= d;
		@(posedge clk);
		wr_i <= 1'b0;
		rd_i <= 1'b1;
		@(negedge clk);
		expect_bit("rhit_o", rhit_o, 1'b1);
		check_hword("rdat_o", rdat_o, merged);
		compare_status("rstat_o", rstat_o, LS_OK);
		wt_adr = a;
		wt_val = merged;
		// Store to a line that is not resident must not allocate
		@(posedge clk);
		rd_i  <= 1'b0;
		wr_i  <= 1'b1;
		adr_i <= cold;
		@(posedge clk);
		wr_i <= 1'b0;
		@(negedge clk);
		expect_bit("rhit_o", rhit_o, 1'b0);
	endtask

	task automatic l2_refill();
		int n;
		invalidate_line(wt_adr);
		fill_and_check(wt_adr, wt_val, LS_OK, 1'b0, n);
		verify_count("l2 fill cycles", n, `DC_L2_LAT + 2 + `DC_L1_WLAT);
	endtask

	task automatic bus_faults(input addr_t first_line);
		lstat_t kinds [3];
		addr_t  line;
		addr_t  a;
		int     n;
		kinds[0] = LS_ERR;
		kinds[1] = LS_WRV;
		kinds[2] = LS_RDV;
		for (int k = 0; k < 3; k++) begin
			line = first_line + addr_t'(16 * k);
			a    = line + addr_t'($urandom & 14);
			// Fault on a random beat of the burst
			fault_adr  = line + addr_t'(4 * ($urandom % `DC_BEATS));
			fault_kind = kinds[k];
			fault_on   = 1'b1;
			fill_and_check(a, 16'h0000, kinds[k], 1'b1, n);
			fault_on = 1'b0;
		end
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		int seed;
		seed = 54845;
		void'($urandom(seed));
		rd_i       = 1'b0;
		wr_i       = 1'b0;
		adr_i      = '0;
		wsel_i     = '0;
		wdat_i     = '0;
		inv_i      = 1'b0;
		inv_adr_i  = '0;
		dat_i      = '0;
		ack_i      = 1'b0;
		err_i      = 1'b0;
		wrv_i      = 1'b0;
		rdv_i      = 1'b0;
		bok_i      = 1'b1;
		fault_on   = 1'b0;
		fault_adr  = '0;
		fault_kind = LS_OK;
		mismatches = 0;
		other_errs = 0;
		checks     = 0;
		exp_fills  = '0;
		wt_adr     = '0;
		wt_val     = '0;
		// Consecutive lines keep every test on its own L1 and L2 index
		base = addr_t'($urandom & 32'hfff0);
		@(negedge clk);
		while (rst_i)
			@(negedge clk);
		expect_bit("cyc_o", cyc_o, 1'b0);
		expect_bit("stb_o", stb_o, 1'b0);
		ctl_field_check("cti_o", {1'b0, cti_o}, 4'b0000);
		expect_bit("done_o", done_o, 1'b0);
		verify_count("fill_cnt_o", fill_cnt_o, 32'd0);
		read_miss_fill(base + addr_t'($urandom & 14));
		nonburst_fill(base + addr_t'(16'h0010 + ($urandom & 14)));
		write_through(base + addr_t'($urandom & 14), base + addr_t'(16'h0050));
		l2_refill();
		bus_faults(base + addr_t'(16'h0020));
		$display("errors: %0d mismatches, %0d other, %0d checks", mismatches, other_errs,
			checks);
		if (mismatches == 0 && other_errs == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Watchdog over the summed test budgets
	initial begin
		repeat (RUN_CYC) @(posedge clk);
		$display("error: run did not finish within %0d cycles", RUN_CYC);
		$display("errors: %0d mismatches, %0d other, %0d checks", mismatches, other_errs + 1,
			checks);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: dcache.f
+incdir+src
src/dcache_pkg.sv
src/dc_controller.sv
src/dc_l1_cache.sv
src/dc_l2_cache.sv
src/dcache_top.sv
verif/tb_clock.sv
verif/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - src
    files:
      - src/dcache_pkg.sv
      - src/dc_controller.sv
      - src/dc_l1_cache.sv
      - src/dc_l2_cache.sv
      - src/dcache_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/tb_clock.sv
      - verif/tb_dcache.sv
